//--- common/eeprom_pkg.sv
package eeprom_pkg;

    // 2 Kbyte array, upper three bits go into the control byte
    localparam int EEPROM_ADDR_W = 11;

    localparam logic [3:0] EEPROM_DEV_CODE = 4'b1010;

    // CLK cycles per scl half period
    localparam int SCL_HALF = 4;

    // commands understood by the bit engine
    typedef enum logic [1:0]
    {
        cmd_start,
        cmd_stop,
        cmd_write_byte,
        cmd_read_byte
    } bit_cmd_e;

    // transaction sequencer states
    typedef enum logic [3:0]
    {
        idle,
        wr_start,       // start condition
        wr_ctrl,        // control byte, write bit
        wr_addr,        // address low byte
        wr_data,
        rd_start,       // repeated start
        rd_ctrl,        // control byte, read bit
        rd_data,
        stop,
        done
    } seq_state_e;

endpackage

//--- common/i2c_bit_if.sv
`timescale 1ns/1ps

interface i2c_bit_if;
    import eeprom_pkg::*;

    bit_cmd_e    cmd;
    logic        cmd_go;     // one cycle, only while engine is free
    logic [7:0]  tx_byte;
    logic [7:0]  rx_byte;    // valid from cmd_done of a read byte
    logic        cmd_done;

    modport seq
    (
        output cmd,
        output cmd_go,
        output tx_byte,
        input  rx_byte,
        input  cmd_done
    );

    modport engine
    (
        input  cmd,
        input  cmd_go,
        input  tx_byte,
        output rx_byte,
        output cmd_done
    );

endinterface

//--- eeprom/eeprom_seq.sv
`timescale 1ns/1ps

module eeprom_seq
(
    input  logic                                 CLK,
    input  logic                                 RESET,
    input  logic                                 wr,
    input  logic                                 rd,
    input  logic [eeprom_pkg::EEPROM_ADDR_W-1:0] addr,
    input  logic [7:0]                           wr_data,
    output logic [7:0]                           rd_data,
    output logic                                 ack,
    i2c_bit_if.seq                               bus
);
    import eeprom_pkg::*;

    seq_state_e               state;
    seq_state_e               next_state;
    logic                     is_read;
    logic                     issued;     // command outstanding at the engine
    logic                     start_req;
    logic [EEPROM_ADDR_W-1:0] addr_q;
    logic [7:0]               data_q;
    logic [7:0]               ctrl_byte;

    // requests only count in idle, wr wins
    assign start_req = (state == idle) && (wr || rd);

    // device code, block select bits, r/w bit
    assign ctrl_byte = {EEPROM_DEV_CODE, addr_q[EEPROM_ADDR_W-1:8], state == rd_ctrl};

    // wr_data and rd_data states share their names with ports
    always_comb
    begin
        next_state  = idle;
        bus.cmd     = cmd_stop;
        bus.tx_byte = 8'h00;
        case (state)
            wr_start:
            begin
                bus.cmd    = cmd_start;
                next_state = wr_ctrl;
            end
            wr_ctrl:
            begin
                bus.cmd     = cmd_write_byte;
                bus.tx_byte = ctrl_byte;
                next_state  = wr_addr;
            end
            wr_addr:
            begin
                bus.cmd     = cmd_write_byte;
                bus.tx_byte = addr_q[7:0];
                next_state  = is_read ? rd_start : eeprom_pkg::wr_data;
            end
            eeprom_pkg::wr_data:
            begin
                bus.cmd     = cmd_write_byte;
                bus.tx_byte = data_q;
                next_state  = stop;
            end
            rd_start:
            begin
                bus.cmd    = cmd_start;
                next_state = rd_ctrl;
            end
            rd_ctrl:
            begin
                bus.cmd     = cmd_write_byte;
                bus.tx_byte = ctrl_byte;
                next_state  = eeprom_pkg::rd_data;
            end
            eeprom_pkg::rd_data:
            begin
                bus.cmd    = cmd_read_byte;
                next_state = stop;
            end
            stop:
            begin
                bus.cmd    = cmd_stop;
                next_state = done;
            end
            default:
            begin
                next_state = idle;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= idle;
            is_read    <= 1'b0;
            issued     <= 1'b0;
            bus.cmd_go <= 1'b0;
            ack        <= 1'b0;
            rd_data    <= 8'h00;
        end
        else
        begin
            bus.cmd_go <= 1'b0;
            ack        <= 1'b0;
            case (state)
                idle:
                begin
                    if (wr)
                    begin
                        is_read <= 1'b0;
                        state   <= wr_start;
                    end
                    else if (rd)
                    begin
                        is_read <= 1'b1;
                        state   <= wr_start;   // dummy write sets the address
                    end
                end
                done:
                begin
                    ack <= 1'b1;
                    if (is_read)
                    begin
                        rd_data <= bus.rx_byte;
                    end
                    state <= idle;
                end
                default:
                begin
                    if (!issued)
                    begin
                        bus.cmd_go <= 1'b1;
                        issued     <= 1'b1;
                    end
                    else if (bus.cmd_done)
                    begin
                        issued <= 1'b0;
                        state  <= next_state;
                    end
                end
            endcase
        end
    end

    // request payload, held for the whole transaction
    always_ff @(posedge CLK)
    begin
        if (start_req)
        begin
            addr_q <= addr;
            data_q <= wr_data;
        end
    end

endmodule

//--- eeprom/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine
(
    input  logic      CLK,
    input  logic      RESET,
    i2c_bit_if.engine bus,
    output logic      scl,
    inout  wire       sda
);
    import eeprom_pkg::*;

    bit_cmd_e                    cmd_q;
    logic                        active;
    logic                        half;       // 0 scl low, 1 scl high
    logic [$clog2(SCL_HALF)-1:0] phase;
    logic [2:0]                  bit_cnt;
    logic [7:0]                  tx_sh;
    logic [7:0]                  rx_sh;
    logic                        sda_low;
    logic                        low_edge;
    logic                        mid_high;
    logic                        period_end;
    logic                        is_byte;
    logic                        last_period;

    // sda moves one cycle after scl falls
    assign low_edge = active && !half && (phase == '0);

    // start/stop edge and read sample point
    assign mid_high = active && half && (int'(phase) == SCL_HALF / 2 - 1);

    assign period_end  = active && half && (int'(phase) == SCL_HALF - 1);
    assign is_byte     = (cmd_q == cmd_write_byte) || (cmd_q == cmd_read_byte);
    assign last_period = !is_byte || (bit_cnt == 3'd7);

    // open drain, high comes from the pull-up
    assign sda = sda_low ? 1'b0 : 1'bz;

    assign bus.rx_byte = rx_sh;

    // scl divider and command sequencing
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active       <= 1'b0;
            half         <= 1'b0;
            phase        <= '0;
            bit_cnt      <= 3'd0;
            cmd_q        <= cmd_start;
            scl          <= 1'b1;
            bus.cmd_done <= 1'b0;
        end
        else
        begin
            bus.cmd_done <= 1'b0;
            if (!active)
            begin
                if (bus.cmd_go)
                begin
                    active  <= 1'b1;
                    cmd_q   <= bus.cmd;
                    half    <= 1'b0;
                    phase   <= '0;
                    bit_cnt <= 3'd0;
                    scl     <= 1'b0;     // every period opens with scl low
                end
            end
            else if (int'(phase) == SCL_HALF - 1)
            begin
                phase <= '0;
                if (!half)
                begin
                    half <= 1'b1;
                    scl  <= 1'b1;
                end
                else if (last_period)
                begin
                    active       <= 1'b0;
                    half         <= 1'b0;
                    bus.cmd_done <= 1'b1;   // scl stays high between commands
                end
                else
                begin
                    half    <= 1'b0;
                    scl     <= 1'b0;
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
            else
            begin
                phase <= phase + 1'b1;
            end
        end
    end

    // sda drive, changes only while scl is low except start and stop
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            sda_low <= 1'b0;
        end
        else if (low_edge)
        begin
            case (cmd_q)
                cmd_start:      sda_low <= 1'b0;      // release before repeated start
                cmd_stop:       sda_low <= 1'b1;
                cmd_write_byte: sda_low <= ~tx_sh[7];
                default:        sda_low <= 1'b0;      // let the slave drive
            endcase
        end
        else if (mid_high)
        begin
            if (cmd_q == cmd_start)
            begin
                sda_low <= 1'b1;    // high to low with scl high
            end
            else if (cmd_q == cmd_stop)
            begin
                sda_low <= 1'b0;    // low to high with scl high
            end
        end
    end

    // shift registers, msb first
    always_ff @(posedge CLK)
    begin
        if (!active && bus.cmd_go)
        begin
            tx_sh <= bus.tx_byte;
        end
        else if (period_end && (cmd_q == cmd_write_byte))
        begin
            tx_sh <= {tx_sh[6:0], 1'b0};
        end

        if (mid_high && (cmd_q == cmd_read_byte))
        begin
            rx_sh <= {rx_sh[6:0], sda};
        end
    end

endmodule

//--- eeprom_ctrl_top.f
common/eeprom_pkg.sv
common/i2c_bit_if.sv
eeprom/eeprom_seq.sv
eeprom/i2c_bit_engine.sv
rtl/eeprom_ctrl_top.sv
verif/eeprom_model.sv
verif/tb_eeprom_ctrl.sv

//--- rtl/eeprom_ctrl_top.sv
`timescale 1ns/1ps

module eeprom_ctrl_top
(
    input  logic                                 CLK,
    input  logic                                 RESET,
    input  logic                                 wr,
    input  logic                                 rd,
    input  logic [eeprom_pkg::EEPROM_ADDR_W-1:0] addr,
    input  logic [7:0]                           wr_data,
    output logic [7:0]                           rd_data,
    output logic                                 ack,
    output logic                                 scl,
    inout  wire                                  sda
);

    // command path between sequencer and bit engine
    i2c_bit_if bus_if ();

    eeprom_seq u_seq
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .bus     (bus_if)
    );

    i2c_bit_engine u_engine
    (
        .CLK   (CLK),
        .RESET (RESET),
        .bus   (bus_if),
        .scl   (scl),
        .sda   (sda)     // pull-up sits outside
    );

endmodule

//--- verif/eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model
(
    input  wire        scl,
    inout  wire        sda,
    output logic       framing_err,
    output logic [7:0] wr_ctrl,      // last control byte with the write bit
    output logic [7:0] rd_ctrl,      // last control byte with the read bit
    output int         write_count
);
    import eeprom_pkg::*;

    logic [7:0]               mem [0:(1 << EEPROM_ADDR_W) - 1];
    logic [EEPROM_ADDR_W-1:0] ptr = '0;
    logic [7:0]               sh = 8'h00;
    logic [7:0]               rd_sh = 8'h00;
    logic                     pending_bit = 1'b0;
    logic                     pending = 1'b0;     // bit seen at scl rise, counts at scl fall
    logic                     drive_low = 1'b0;
    logic                     in_txn = 1'b0;
    logic                     addr_set = 1'b0;
    logic                     rep_start = 1'b0;
    logic                     reading = 1'b0;
    int                       bit_cnt = 0;
    int                       byte_idx = 0;
    int                       rd_cnt = 0;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        framing_err = 1'b0;
        wr_ctrl     = 8'h00;
        rd_ctrl     = 8'h00;
        write_count = 0;
        for (int a = 0; a < (1 << EEPROM_ADDR_W); a++)
            mem[a] = a[7:0] ^ a[EEPROM_ADDR_W-1:8];
    end

    task automatic take_byte(input logic [7:0] b);
        case (byte_idx)
            0:
            begin
                if (b[7:4] != EEPROM_DEV_CODE)
                    framing_err = 1'b1;
                if (b[0])
                begin
                    if (!rep_start)
                        framing_err = 1'b1;   // read without a repeated start
                    rd_ctrl = b;
                    rd_sh   = mem[{b[3:1], ptr[7:0]}];
                    reading = 1'b1;
                    rd_cnt  = 0;
                end
                else
                begin
                    wr_ctrl               = b;
                    ptr[EEPROM_ADDR_W-1:8] = b[3:1];
                end
            end
            1:
            begin
                ptr[7:0] = b;
                addr_set = 1'b1;
            end
            2:
            begin
                mem[ptr] = b;
                write_count++;
            end
            default: framing_err = 1'b1;   // no page writes
        endcase
        byte_idx++;
    endtask

    // sda edges with scl high are start or stop
    always @(sda)
    begin
        if (scl === 1'b1 && (sda === 1'b0 || sda === 1'b1))
        begin
            if (bit_cnt != 0 || reading)
                framing_err = 1'b1;   // start or stop inside a byte
            rep_start = (sda === 1'b0) && in_txn && addr_set;
            in_txn    = (sda === 1'b0);
            addr_set  = addr_set && in_txn;
            pending   = 1'b0;
            bit_cnt   = 0;
            byte_idx  = 0;
        end
    end

    always @(scl)
    begin
        if (scl === 1'b1)
        begin
            if (in_txn && !reading)
            begin
                pending     = 1'b1;
                pending_bit = sda;
            end
        end
        else if (scl === 1'b0)
        begin
            if (pending)
            begin
                pending = 1'b0;
                sh      = {sh[6:0], pending_bit};
                bit_cnt++;
                if (bit_cnt == 8)
                begin
                    bit_cnt = 0;
                    take_byte(sh);
                end
            end
            if (reading)
            begin
                drive_low = (rd_cnt < 8) ? !rd_sh[7] : 1'b0;
                reading   = (rd_cnt < 8);
                rd_sh     = {rd_sh[6:0], 1'b0};
                rd_cnt++;
            end
        end
    end

endmodule

//--- verif/tb_eeprom_ctrl.sv
`timescale 1ns/1ps

module tb_eeprom_ctrl;
    import eeprom_pkg::*;

    // write/read pairs over all tests, one read plus slack
    localparam int TEST_COUNT = 45;
    localparam int TXN_CYCLES = 40 * 2 * SCL_HALF;

    logic                     CLK = 1'b0;
    logic                     RESET = 1'b1;
    logic                     wr = 1'b0;
    logic                     rd = 1'b0;
    logic [EEPROM_ADDR_W-1:0] addr = '0;
    logic [7:0]               wr_data = 8'h00;
    logic [7:0]               rd_data;
    logic                     ack;
    logic                     scl;
    wire                      sda;
    logic                     framing_err;
    logic [7:0]               wr_ctrl;
    logic [7:0]               rd_ctrl;
    int                       write_count;
    logic [7:0]               shadow [0:(1 << EEPROM_ADDR_W) - 1];
    logic [EEPROM_ADDR_W-1:0] cur_addr = '0;
    logic                     cur_is_read = 1'b0;
    logic                     ack_prev = 1'b0;
    int                       ack_count = 0;
    int                       txn_count = 0;
    int                       errors = 0;
    int                       errors_at_start = 0;
    int                       test_num = 0;
    int                       tests_failed = 0;
    integer                   seed = 32'hb16e87d0;

    eeprom_ctrl_top UUT (.*);
    eeprom_model bus_model (.*);
    pullup (sda);

    always #5 CLK = ~CLK;

    function automatic logic [7:0] expected_byte(input logic [EEPROM_ADDR_W-1:0] a);
        return shadow[a];
    endfunction

    task automatic log_mismatch(input string name, input logic [7:0] got, input logic [7:0] exp);
        $display("ERROR %s: got %h, expected %h", name, got, exp);
        errors++;
    endtask

    task automatic log_failure(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic end_test(input string name);
        assert (ack_count == txn_count) else log_failure("ack count does not match requests");
        test_num++;
        if (errors == errors_at_start)
            $display("test %0d %s: passed", test_num, name);
        else
        begin
            $display("test %0d %s: failed with %0d errors", test_num, name,
                     errors - errors_at_start);
            tests_failed++;
        end
        errors_at_start = errors;
    endtask

    task automatic run_txn(input logic is_read, input logic [EEPROM_ADDR_W-1:0] a,
                           input logic [7:0] d);
        int acks_before;
        @(negedge CLK);
        acks_before = ack_count;
        cur_addr    = a;
        cur_is_read = is_read;
        addr        = a;
        wr_data     = d;
        wr          = !is_read;
        rd          = is_read;
        txn_count++;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        while (ack_count == acks_before)
            @(negedge CLK);
        if (!is_read)
            shadow[a] = d;
    endtask

    // stray requests in the middle of a write
    task automatic pulse_requests(input logic [EEPROM_ADDR_W-1:0] a, input logic [7:0] d);
        repeat (40) @(negedge CLK);
        addr    = a;
        wr_data = d;
        wr      = 1'b1;
        @(negedge CLK);
        wr = 1'b0;
        repeat (60) @(negedge CLK);
        rd = 1'b1;
        @(negedge CLK);
        rd = 1'b0;
    endtask

    // compare at every ack
    always @(negedge CLK)
    begin
        if (!RESET)
        begin
            assert (!(ack && ack_prev)) else log_failure("ack was high for more than one cycle");
            if (ack)
            begin
                ack_count++;
                assert (wr_ctrl == {EEPROM_DEV_CODE, cur_addr[EEPROM_ADDR_W-1:8], 1'b0})
                    else log_mismatch("wr_ctrl", wr_ctrl, {4'ha, cur_addr[10:8], 1'b0});
                if (cur_is_read)
                begin
                    assert (rd_ctrl == {EEPROM_DEV_CODE, cur_addr[EEPROM_ADDR_W-1:8], 1'b1})
                        else log_mismatch("rd_ctrl", rd_ctrl, {4'ha, cur_addr[10:8], 1'b1});
                    assert (rd_data == expected_byte(cur_addr))
                        else log_mismatch("rd_data", rd_data, expected_byte(cur_addr));
                end
            end
            ack_prev = ack;
        end
    end

    initial
    begin
        #((TEST_COUNT * TXN_CYCLES * 2 + 4 * TXN_CYCLES) * 10);
        $display("watchdog expired before the tests completed");
        $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin
        logic [EEPROM_ADDR_W-1:0] a;
        logic [7:0]               d;
        int                       writes_before;
        for (int i = 0; i < (1 << EEPROM_ADDR_W); i++)
            shadow[i] = i[7:0] ^ i[10:8];
        repeat (10) @(negedge CLK);
        RESET = 1'b0;

        repeat (50)
        begin
            @(negedge CLK);
            assert (ack === 1'b0) else log_mismatch("ack", {7'd0, ack}, 8'h00);
            assert (scl === 1'b1) else log_mismatch("scl", {7'd0, scl}, 8'h01);
            assert (sda === 1'b1) else log_mismatch("sda", {7'd0, sda}, 8'h01);
        end
        end_test("idle after reset");

        run_txn(1'b0, 11'h3a7, 8'h5a);
        run_txn(1'b1, 11'h3a7, 8'h00);
        end_test("write then read");

        run_txn(1'b1, 11'h5e7, 8'h00);   // never written
        end_test("read of init pattern");

        for (int i = 0; i < 40; i++)
        begin
            a = $random(seed);
            a[EEPROM_ADDR_W-1:8] = i[2:0];
            d = $random(seed);
            run_txn(1'b0, a, d);
            if (i % 2 != 0)
                a = $random(seed);
            run_txn(1'b1, a, 8'h00);
        end
        end_test("random writes and reads");

        writes_before = write_count;
        fork
            run_txn(1'b0, 11'h2c5, 8'h3c);
            pulse_requests(11'h6a1, 8'hc3);
        join
        repeat (2 * TXN_CYCLES) @(negedge CLK);
        assert (write_count == writes_before + 1) else log_failure("ignored request was written");
        run_txn(1'b1, 11'h6a1, 8'h00);
        run_txn(1'b1, 11'h2c5, 8'h00);
        end_test("requests during a transaction");

        assert (framing_err === 1'b0) else log_failure("bus model flagged a framing error");
        end_test("bus framing");

        $display("tests %0d, failed %0d, errors %0d", test_num, tests_failed, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
